//--- cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache package
// sizes and types shared by the split cache and the burst RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cache_pkg;

  // core side
  localparam int addr_w = 32;
  localparam int word_w = 32;
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [word_w-1:0] word_t;
  typedef logic [word_w/8-1:0] byte_en_t;

  // byte address is {tag, line index, word index, word offset}
  localparam int word_off_w = 2;
  localparam int word_ix_w = 3;
  localparam int line_ix_w = 3;
  localparam int line_off_w = word_off_w + word_ix_w;
  localparam int cache_lines = 2 ** line_ix_w;

  // burst RAM geometry
  localparam int ram_depth_w = 4;
  localparam int ram_lines = 2 ** ram_depth_w;
  typedef logic [ram_depth_w-1:0] ram_addr_t;

  // the tag is whatever the RAM line address has beyond the cache index
  localparam int tag_w = ram_depth_w - line_ix_w;
  typedef logic [tag_w-1:0] tag_t;

  // one beat carries two words, a line is four beats
  localparam int burst_w = 64;
  localparam int burst_count = 4;
  localparam int beat_ix_w = $clog2(burst_count);
  typedef logic [burst_w-1:0] beat_t;
  typedef logic [burst_w/8-1:0] beat_mask_t;
  typedef logic [beat_ix_w-1:0] beat_ix_t;

  // one-bit RAM command
  localparam logic ram_cmd_read = 1'b0;
  localparam logic ram_cmd_write = 1'b1;

endpackage

`default_nettype wire

//--- burst_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// burst RAM
// line-organized memory with 4-beat read and masked write bursts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module burst_ram (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          cmd,
  input  wire                          cmd_en,
  input  wire cache_pkg::ram_addr_t    addr,
  input  wire cache_pkg::beat_t        wr_data,
  input  wire cache_pkg::beat_mask_t   data_mask,
  output cache_pkg::beat_t             rd_data,
  output logic                         rd_data_valid,
  output logic                         busy
);

  typedef enum logic [1:0] {st_idle, st_write, st_rd_lat, st_read} state_t;

  localparam int mem_depth = cache_pkg::ram_lines * cache_pkg::burst_count;

  cache_pkg::beat_t mem [mem_depth];
  state_t state;
  cache_pkg::ram_addr_t line_q;
  cache_pkg::ram_addr_t line_sel;
  cache_pkg::beat_ix_t beat_cnt;
  logic write_now;

  // beat 0 of a write comes with the command, the rest follow the counter
  assign write_now = (state == st_idle && cmd_en && cmd == cache_pkg::ram_cmd_write) ||
                     state == st_write;
  assign line_sel = (state == st_idle) ? addr : line_q;

  // beat_cnt is zero whenever the RAM is idle
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      busy <= 1'b0;
      rd_data_valid <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (cmd_en) begin
            busy <= 1'b1;
            if (cmd == cache_pkg::ram_cmd_write) begin
              beat_cnt <= beat_cnt + 1'b1;
              state <= st_write;
            end else begin
              state <= st_rd_lat;
            end
          end
        end
        st_write: begin
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == '1) begin
            busy <= 1'b0;
            state <= st_idle;
          end
        end
        st_rd_lat: begin
          rd_data_valid <= 1'b1;
          beat_cnt <= beat_cnt + 1'b1;
          state <= st_read;
        end
        st_read: begin
          // counter wrapped, so the last beat is on the bus now
          if (beat_cnt == '0) begin
            rd_data_valid <= 1'b0;
            busy <= 1'b0;
            state <= st_idle;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // each word holds c0de over its own byte address
      for (int i = 0; i < mem_depth; i++) begin
        mem[i] <= {16'hc0de, 16'(i * 8 + 4), 16'hc0de, 16'(i * 8)};
      end
    end else if (write_now) begin
      for (int b = 0; b < cache_pkg::burst_w / 8; b++) begin
        if (data_mask[b]) begin
          mem[{line_sel, beat_cnt}][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
    if (state == st_idle && cmd_en) begin
      line_q <= addr;
    end
    rd_data <= mem[{line_q, beat_cnt}];
  end

endmodule

`default_nettype wire

//--- cache_instr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction cache
// read-only direct-mapped cache, refills a line with one read burst
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_instr (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        enable,
  input  wire cache_pkg::addr_t      address,
  output cache_pkg::word_t           data,
  output logic                       data_valid,
  output logic                       busy,
  output logic                       br_cmd,
  output logic                       br_cmd_en,
  output cache_pkg::ram_addr_t       br_addr,
  input  wire cache_pkg::beat_t      br_rd_data,
  input  wire                        br_rd_data_valid,
  input  wire                        br_busy
);

  typedef enum logic [1:0] {st_idle, st_lookup, st_issue, st_fill} state_t;

  localparam int store_depth = cache_pkg::cache_lines * cache_pkg::burst_count;

  cache_pkg::beat_t store [store_depth];
  cache_pkg::tag_t tags [cache_pkg::cache_lines];
  logic [cache_pkg::cache_lines-1:0] line_valid;
  state_t state;
  cache_pkg::addr_t addr_q;
  cache_pkg::beat_ix_t beat_cnt;

  logic [cache_pkg::word_ix_w-1:0] word_ix;
  logic [cache_pkg::line_ix_w-1:0] line_ix;
  cache_pkg::tag_t tag;
  cache_pkg::beat_t sel_beat;
  cache_pkg::word_t sel_word;
  logic hit;
  logic fill_beat;

  // split the held address
  assign word_ix = addr_q[cache_pkg::word_off_w +: cache_pkg::word_ix_w];
  assign line_ix = addr_q[cache_pkg::line_off_w +: cache_pkg::line_ix_w];
  assign tag = addr_q[cache_pkg::line_off_w + cache_pkg::line_ix_w +: cache_pkg::tag_w];

  assign hit = line_valid[line_ix] && tags[line_ix] == tag;
  assign sel_beat = store[{line_ix, word_ix[cache_pkg::word_ix_w-1:1]}];
  assign sel_word = word_ix[0] ? sel_beat[cache_pkg::word_w +: cache_pkg::word_w] :
                                 sel_beat[0 +: cache_pkg::word_w];

  // refills only, and only while this port owns the RAM
  assign br_cmd = cache_pkg::ram_cmd_read;
  assign br_addr = addr_q[cache_pkg::line_off_w +: cache_pkg::ram_depth_w];
  assign br_cmd_en = state == st_issue && enable && !br_busy;
  assign fill_beat = state == st_fill && enable && br_rd_data_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      busy <= 1'b0;
      data_valid <= 1'b0;
      line_valid <= '0;
      beat_cnt <= '0;
    end else begin
      data_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (enable) begin
            busy <= 1'b1;
            state <= st_lookup;
          end
        end
        st_lookup: begin
          if (hit) begin
            data_valid <= 1'b1;
            busy <= 1'b0;
            state <= st_idle;
          end else begin
            state <= st_issue;
          end
        end
        st_issue: begin
          if (br_cmd_en) begin
            state <= st_fill;
          end
        end
        st_fill: begin
          if (fill_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            // line complete, look it up again to return the word
            if (beat_cnt == '1) begin
              line_valid[line_ix] <= 1'b1;
              state <= st_lookup;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && enable) begin
      addr_q <= address;
    end
    if (state == st_lookup && hit) begin
      data <= sel_word;
    end
    if (fill_beat) begin
      store[{line_ix, beat_cnt}] <= br_rd_data;
      tags[line_ix] <= tag;
    end
  end

endmodule

`default_nettype wire

//--- cache_data.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache
// direct-mapped write-through cache with byte enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_data (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          enable,
  input  wire cache_pkg::byte_en_t     write_enable_bytes,
  input  wire cache_pkg::addr_t        address,
  input  wire cache_pkg::word_t        data_in,
  output cache_pkg::word_t             data_out,
  output logic                         data_out_valid,
  output logic                         busy,
  output logic                         br_cmd,
  output logic                         br_cmd_en,
  output cache_pkg::ram_addr_t         br_addr,
  output cache_pkg::beat_t             br_wr_data,
  output cache_pkg::beat_mask_t        br_data_mask,
  input  wire cache_pkg::beat_t        br_rd_data,
  input  wire                          br_rd_data_valid,
  input  wire                          br_busy
);

  typedef enum logic [2:0] {st_idle, st_lookup, st_issue, st_write, st_fill} state_t;

  localparam int store_depth = cache_pkg::cache_lines * cache_pkg::burst_count;
  localparam int word_bytes = cache_pkg::word_w / 8;

  cache_pkg::beat_t store [store_depth];
  cache_pkg::tag_t tags [cache_pkg::cache_lines];
  logic [cache_pkg::cache_lines-1:0] line_valid;
  state_t state;
  cache_pkg::addr_t addr_q;
  cache_pkg::byte_en_t we_q;
  cache_pkg::word_t din_q;
  cache_pkg::beat_ix_t beat_cnt;

  logic [cache_pkg::word_ix_w-1:0] word_ix;
  logic [cache_pkg::line_ix_w-1:0] line_ix;
  cache_pkg::beat_ix_t word_beat;
  cache_pkg::tag_t tag;
  cache_pkg::beat_t sel_beat;
  cache_pkg::beat_t merged;
  cache_pkg::word_t sel_word;
  logic is_write;
  logic accept;
  logic hit;
  logic fill_beat;

  assign word_ix = addr_q[cache_pkg::word_off_w +: cache_pkg::word_ix_w];
  assign line_ix = addr_q[cache_pkg::line_off_w +: cache_pkg::line_ix_w];
  assign tag = addr_q[cache_pkg::line_off_w + cache_pkg::line_ix_w +: cache_pkg::tag_w];
  assign word_beat = word_ix[cache_pkg::word_ix_w-1:1];

  assign is_write = we_q != '0;
  // no new request in the valid cycle, the core still shows the old one
  assign accept = state == st_idle && enable && !data_out_valid;
  assign hit = line_valid[line_ix] && tags[line_ix] == tag;
  assign sel_beat = store[{line_ix, word_beat}];
  assign sel_word = word_ix[0] ? sel_beat[cache_pkg::word_w +: cache_pkg::word_w] :
                                 sel_beat[0 +: cache_pkg::word_w];

  // enabled bytes of the new word merged into the cached beat
  always_comb begin
    merged = sel_beat;
    for (int b = 0; b < word_bytes; b++) begin
      if (we_q[b]) begin
        merged[(word_ix[0] ? cache_pkg::word_w : 0) + b*8 +: 8] = din_q[b*8 +: 8];
      end
    end
  end

  assign br_cmd = is_write ? cache_pkg::ram_cmd_write : cache_pkg::ram_cmd_read;
  assign br_addr = addr_q[cache_pkg::line_off_w +: cache_pkg::ram_depth_w];
  assign br_cmd_en = state == st_issue && enable && !br_busy;
  assign br_wr_data = {din_q, din_q};
  assign fill_beat = state == st_fill && enable && br_rd_data_valid;

  // mask is nonzero only on the beat and half that hold the word
  always_comb begin
    br_data_mask = '0;
    if (is_write && (state == st_issue || state == st_write) && beat_cnt == word_beat) begin
      if (word_ix[0]) begin
        br_data_mask[word_bytes +: word_bytes] = we_q;
      end else begin
        br_data_mask[0 +: word_bytes] = we_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      busy <= 1'b0;
      data_out_valid <= 1'b0;
      line_valid <= '0;
      beat_cnt <= '0;
    end else begin
      data_out_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            busy <= 1'b1;
            state <= st_lookup;
          end
        end
        st_lookup: begin
          if (is_write) begin
            state <= st_issue;
          end else if (hit) begin
            data_out_valid <= 1'b1;
            busy <= 1'b0;
            state <= st_idle;
          end else begin
            state <= st_issue;
          end
        end
        st_issue: begin
          if (br_cmd_en) begin
            if (is_write) begin
              beat_cnt <= beat_cnt + 1'b1;
              state <= st_write;
            end else begin
              state <= st_fill;
            end
          end
        end
        st_write: begin
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == '1) begin
            data_out_valid <= 1'b1;
            busy <= 1'b0;
            state <= st_idle;
          end
        end
        st_fill: begin
          if (fill_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == '1) begin
              line_valid[line_ix] <= 1'b1;
              state <= st_lookup;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= address;
      we_q <= write_enable_bytes;
      din_q <= data_in;
    end
    if (state == st_lookup && !is_write && hit) begin
      data_out <= sel_word;
    end
    // write miss leaves the cache alone
    if (state == st_lookup && is_write && hit) begin
      store[{line_ix, word_beat}] <= merged;
    end
    if (fill_beat) begin
      store[{line_ix, beat_cnt}] <= br_rd_data;
      tags[line_ix] <= tag;
    end
  end

endmodule

`default_nettype wire

//--- cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// split cache
// instruction and data caches sharing one burst RAM port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache (
  input  wire                          clk,
  input  wire                          rst,

  // port a, data
  input  wire                          en_a,
  input  wire cache_pkg::byte_en_t     we_a,
  input  wire cache_pkg::addr_t        addr_a,
  input  wire cache_pkg::word_t        din_a,
  output cache_pkg::word_t             dout_a,
  output logic                         valid_a,
  output logic                         busy_a,

  // port b, instructions
  input  wire cache_pkg::addr_t        addr_b,
  output cache_pkg::word_t             dout_b,
  output logic                         valid_b,
  output logic                         busy_b,

  // burst RAM
  output logic                         br_cmd,
  output logic                         br_cmd_en,
  output cache_pkg::ram_addr_t         br_addr,
  output cache_pkg::beat_t             br_wr_data,
  output cache_pkg::beat_mask_t        br_data_mask,
  input  wire cache_pkg::beat_t        br_rd_data,
  input  wire                          br_rd_data_valid,
  input  wire                          br_busy
);

  typedef enum logic [1:0] {st_i_settle, st_i_wait, st_d_settle, st_d_wait} state_t;

  state_t state;
  logic grant_d;
  logic i_enable;
  logic d_enable;

  logic i_cmd;
  logic i_cmd_en;
  cache_pkg::ram_addr_t i_addr;
  logic d_cmd;
  logic d_cmd_en;
  cache_pkg::ram_addr_t d_addr;

  assign grant_d = state == st_d_settle || state == st_d_wait;
  assign i_enable = !grant_d;
  // data cache only sees a request while it holds the grant
  assign d_enable = grant_d && en_a;

  cache_instr u_icache (
    .clk              (clk),
    .rst              (rst),
    .enable           (i_enable),
    .address          (addr_b),
    .data             (dout_b),
    .data_valid       (valid_b),
    .busy             (busy_b),
    .br_cmd           (i_cmd),
    .br_cmd_en        (i_cmd_en),
    .br_addr          (i_addr),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid),
    .br_busy          (br_busy)
  );

  cache_data u_dcache (
    .clk                (clk),
    .rst                (rst),
    .enable             (d_enable),
    .write_enable_bytes (we_a),
    .address            (addr_a),
    .data_in            (din_a),
    .data_out           (dout_a),
    .data_out_valid     (valid_a),
    .busy               (busy_a),
    .br_cmd             (d_cmd),
    .br_cmd_en          (d_cmd_en),
    .br_addr            (d_addr),
    .br_wr_data         (br_wr_data),
    .br_data_mask       (br_data_mask),
    .br_rd_data         (br_rd_data),
    .br_rd_data_valid   (br_rd_data_valid),
    .br_busy            (br_busy)
  );

  // command lines follow the grant
  assign br_cmd = grant_d ? d_cmd : i_cmd;
  assign br_cmd_en = grant_d ? d_cmd_en : i_cmd_en;
  assign br_addr = grant_d ? d_addr : i_addr;

  // settle states leave one cycle for the new owner's busy to rise
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_i_settle;
    end else begin
      case (state)
        st_i_settle: state <= st_i_wait;
        st_i_wait: begin
          if (!busy_b && en_a) begin
            state <= st_d_settle;
          end
        end
        st_d_settle: state <= st_d_wait;
        st_d_wait: begin
          if (!busy_a) begin
            state <= st_i_settle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cache_system.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache system
// split cache joined to the on-chip burst RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_system (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          en_a,
  input  wire cache_pkg::byte_en_t     we_a,
  input  wire cache_pkg::addr_t        addr_a,
  input  wire cache_pkg::word_t        din_a,
  output cache_pkg::word_t             dout_a,
  output logic                         valid_a,
  output logic                         busy_a,
  input  wire cache_pkg::addr_t        addr_b,
  output cache_pkg::word_t             dout_b,
  output logic                         valid_b,
  output logic                         busy_b
);

  logic br_cmd;
  logic br_cmd_en;
  cache_pkg::ram_addr_t br_addr;
  cache_pkg::beat_t br_wr_data;
  cache_pkg::beat_mask_t br_data_mask;
  cache_pkg::beat_t br_rd_data;
  logic br_rd_data_valid;
  logic br_busy;

  cache u_cache (
    .clk              (clk),
    .rst              (rst),
    .en_a             (en_a),
    .we_a             (we_a),
    .addr_a           (addr_a),
    .din_a            (din_a),
    .dout_a           (dout_a),
    .valid_a          (valid_a),
    .busy_a           (busy_a),
    .addr_b           (addr_b),
    .dout_b           (dout_b),
    .valid_b          (valid_b),
    .busy_b           (busy_b),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_data_mask     (br_data_mask),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid),
    .br_busy          (br_busy)
  );

  burst_ram u_ram (
    .clk           (clk),
    .rst           (rst),
    .cmd           (br_cmd),
    .cmd_en        (br_cmd_en),
    .addr          (br_addr),
    .wr_data       (br_wr_data),
    .data_mask     (br_data_mask),
    .rd_data       (br_rd_data),
    .rd_data_valid (br_rd_data_valid),
    .busy          (br_busy)
  );

endmodule

`default_nettype wire

//--- tb_cache_system.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache system testbench
// random fetches and data accesses checked against a byte model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_cache_system;

  localparam int n_fetch_ops = 48;
  localparam int n_data_iter = 32;
  localparam int n_data_ops = 2 * n_data_iter + n_data_iter / 4;
  localparam int n_pair_ops = 32;
  localparam int n_mix_ops = 300;
  localparam int total_ops = n_fetch_ops + n_data_ops + 2 * n_pair_ops + n_mix_ops;
  localparam int cycle_limit = total_ops * 40;
  localparam int stall_limit = 200;
  localparam int mem_bytes = 512;

  logic clk;
  logic rst;
  logic en_a;
  cache_pkg::byte_en_t we_a;
  cache_pkg::addr_t addr_a;
  cache_pkg::word_t din_a;
  cache_pkg::word_t dout_a;
  logic valid_a;
  logic busy_a;
  cache_pkg::addr_t addr_b;
  cache_pkg::word_t dout_b;
  logic valid_b;
  logic busy_b;

  // byte model of the whole RAM
  logic [7:0] model [mem_bytes];

  cache_pkg::addr_t fetch_q [$];
  cache_pkg::addr_t dreq_addr_q [$];
  cache_pkg::byte_en_t dreq_we_q [$];
  cache_pkg::word_t dreq_din_q [$];

  logic b_active;
  logic a_active;
  logic aborted;
  int b_wait;
  int a_wait;
  int cycle_count;
  int check_count;
  int error_count;
  int op_count;

  cache_system uut (
    .clk     (clk),
    .rst     (rst),
    .en_a    (en_a),
    .we_a    (we_a),
    .addr_a  (addr_a),
    .din_a   (din_a),
    .dout_a  (dout_a),
    .valid_a (valid_a),
    .busy_a  (busy_a),
    .addr_b  (addr_b),
    .dout_b  (dout_b),
    .valid_b (valid_b),
    .busy_b  (busy_b)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // every word starts as c0de over its own byte address, little endian
  task automatic model_reset;
    cache_pkg::word_t w;
    for (int a = 0; a < mem_bytes; a += 4) begin
      w = {16'hc0de, 16'(a)};
      model[9'(a)] = w[7:0];
      model[9'(a + 1)] = w[15:8];
      model[9'(a + 2)] = w[23:16];
      model[9'(a + 3)] = w[31:24];
    end
  endtask

  function automatic cache_pkg::word_t model_word(input cache_pkg::addr_t addr);
    logic [8:0] base;
    base = {addr[8:2], 2'b00};
    return {model[base + 9'd3], model[base + 9'd2], model[base + 9'd1], model[base]};
  endfunction

  task automatic model_write(input cache_pkg::addr_t addr, input cache_pkg::byte_en_t we,
                             input cache_pkg::word_t din);
    logic [8:0] base;
    base = {addr[8:2], 2'b00};
    if (we[0]) model[base] = din[7:0];
    if (we[1]) model[base + 9'd1] = din[15:8];
    if (we[2]) model[base + 9'd2] = din[23:16];
    if (we[3]) model[base + 9'd3] = din[31:24];
  endtask

  // word aligned byte address in [lo, hi)
  function automatic cache_pkg::addr_t rand_addr(input int unsigned lo, input int unsigned hi);
    int unsigned w;
    w = $urandom_range(hi / 4 - 1, lo / 4);
    return cache_pkg::addr_t'(w * 4);
  endfunction

  function automatic cache_pkg::byte_en_t rand_we();
    return cache_pkg::byte_en_t'($urandom_range(15, 1));
  endfunction

  task automatic push_data(input cache_pkg::addr_t addr, input cache_pkg::byte_en_t we,
                           input cache_pkg::word_t din);
    dreq_addr_q.push_back(addr);
    dreq_we_q.push_back(we);
    dreq_din_q.push_back(din);
  endtask

  task automatic check_data(input cache_pkg::addr_t addr, input cache_pkg::word_t got,
                            input cache_pkg::word_t expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("mismatch at %0t: data read of %h returned %h, expected %h",
               $time, addr, got, expected);
    end
  endtask

  task automatic check_instr(input cache_pkg::addr_t addr, input cache_pkg::word_t got,
                             input cache_pkg::word_t expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("mismatch at %0t: fetch of %h returned %h, expected %h",
               $time, addr, got, expected);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  task automatic finish_run;
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $display("checks: %0d, errors: %0d, ops: %0d, cycles: %0d",
             check_count, error_count, op_count, cycle_count);
    $finish;
  endtask

  // port b fetches all the time, so its address only moves on a valid pulse
  task automatic serve_port_b;
    if (valid_b) begin
      check_instr(addr_b, dout_b, model_word(addr_b));
      check_flag("busy_b with valid_b", busy_b, 1'b0);
      if (b_active) op_count++;
      b_wait = 0;
      if (fetch_q.size() > 0) begin
        addr_b = fetch_q.pop_front();
        b_active = 1'b1;
      end else begin
        // park on word 0 between tests
        addr_b = '0;
        b_active = 1'b0;
      end
    end else begin
      b_wait++;
      if (b_wait > stall_limit) begin
        error_count++;
        $display("port b fetch of %h got no valid pulse within %0d cycles", addr_b, stall_limit);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic serve_port_a;
    if (a_active && valid_a) begin
      if (we_a == '0) begin
        check_data(addr_a, dout_a, model_word(addr_a));
      end else begin
        model_write(addr_a, we_a, din_a);
      end
      check_flag("busy_a with valid_a", busy_a, 1'b0);
      op_count++;
      a_active = 1'b0;
      en_a = 1'b0;
    end else if (a_active) begin
      a_wait++;
      if (a_wait > stall_limit) begin
        error_count++;
        $display("port a request to %h got no valid pulse within %0d cycles", addr_a, stall_limit);
        aborted = 1'b1;
      end
    end else if (valid_a) begin
      error_count++;
      $display("valid_a pulsed at %0t with no request pending", $time);
    end
    if (!a_active && dreq_addr_q.size() > 0) begin
      addr_a = dreq_addr_q.pop_front();
      we_a = dreq_we_q.pop_front();
      din_a = dreq_din_q.pop_front();
      en_a = 1'b1;
      a_active = 1'b1;
      a_wait = 0;
    end
  endtask

  // one clock, inputs move 1 ns after the edge
  task automatic tick;
    @(posedge clk);
    #1;
    if (!aborted) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        error_count++;
        $display("timeout: the run went past %0d cycles", cycle_limit);
        aborted = 1'b1;
      end else begin
        serve_port_b();
        if (!aborted) begin
          serve_port_a();
        end
      end
    end
  endtask

  task automatic run_ops;
    while (!aborted &&
           (fetch_q.size() > 0 || b_active || dreq_addr_q.size() > 0 || a_active)) begin
      tick();
    end
  endtask

  task automatic report_test(input string name, input int op_before, input int err_before);
    $display("test %s done: %0d ops, %0d errors", name, op_count - op_before,
             error_count - err_before);
  endtask

  task automatic test_reset_idle;
    int err_before;
    err_before = error_count;
    rst = 1'b1;
    for (int i = 0; i < 8; i++) begin
      tick();
      check_flag("valid_a in reset", valid_a, 1'b0);
      check_flag("valid_b in reset", valid_b, 1'b0);
      check_flag("busy_a in reset", busy_a, 1'b0);
      check_flag("busy_b in reset", busy_b, 1'b0);
      check_flag("br_cmd_en in reset", uut.br_cmd_en, 1'b0);
    end
    rst = 1'b0;
    // port a has no request, port b keeps fetching its parked address
    for (int i = 0; i < 12; i++) begin
      tick();
      check_flag("valid_a while idle", valid_a, 1'b0);
      check_flag("busy_a while idle", busy_a, 1'b0);
    end
    report_test("reset_idle", op_count, err_before);
  endtask

  // no data writes yet, so fetches may span both tags
  task automatic test_fetch;
    int err_before;
    int op_before;
    int line;
    err_before = error_count;
    op_before = op_count;
    // same index with alternating tags first
    for (int i = 0; i < 16; i++) begin
      line = (i % 2) * 8 + i / 2;
      fetch_q.push_back(cache_pkg::addr_t'(line * 32 + $urandom_range(7, 0) * 4));
    end
    for (int i = 16; i < n_fetch_ops; i++) begin
      fetch_q.push_back(rand_addr(0, 512));
    end
    run_ops();
    report_test("fetch", op_before, err_before);
  endtask

  task automatic test_data;
    cache_pkg::addr_t written [$];
    cache_pkg::addr_t wa;
    int err_before;
    int op_before;
    err_before = error_count;
    op_before = op_count;
    for (int i = 0; i < n_data_iter; i++) begin
      wa = rand_addr(256, 512);
      written.push_back(wa);
      push_data(wa, rand_we(), cache_pkg::word_t'($urandom()));
      push_data(written[$urandom_range(written.size() - 1, 0)], '0, '0);
      // reads below 256 evict written lines through the shared index
      if (i % 4 == 3) begin
        push_data(rand_addr(0, 512), '0, '0);
      end
    end
    run_ops();
    report_test("data", op_before, err_before);
  endtask

  task automatic test_concurrent;
    int err_before;
    int op_before;
    err_before = error_count;
    op_before = op_count;
    for (int i = 0; i < n_pair_ops; i++) begin
      fetch_q.push_back(rand_addr(0, 256));
      if ($urandom_range(1, 0) == 1) begin
        push_data(rand_addr(256, 512), rand_we(), cache_pkg::word_t'($urandom()));
      end else begin
        push_data(rand_addr(0, 512), '0, '0);
      end
    end
    run_ops();
    report_test("concurrent", op_before, err_before);
  endtask

  task automatic test_mix;
    int err_before;
    int op_before;
    int unsigned kind;
    err_before = error_count;
    op_before = op_count;
    for (int i = 0; i < n_mix_ops; i++) begin
      kind = $urandom_range(9, 0);
      if (kind < 4) begin
        fetch_q.push_back(rand_addr(0, 256));
      end else if (kind < 7) begin
        push_data(rand_addr(0, 512), '0, '0);
      end else begin
        push_data(rand_addr(256, 512), rand_we(), cache_pkg::word_t'($urandom()));
      end
    end
    run_ops();
    report_test("mix", op_before, err_before);
  endtask

  initial begin
    rst = 1'b1;
    en_a = 1'b0;
    we_a = '0;
    addr_a = '0;
    din_a = '0;
    addr_b = '0;
    b_active = 1'b0;
    a_active = 1'b0;
    aborted = 1'b0;
    b_wait = 0;
    a_wait = 0;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    op_count = 0;
    void'($urandom(32'ha728_160c));
    model_reset();
    test_reset_idle();
    test_fetch();
    test_data();
    test_concurrent();
    test_mix();
    finish_run();
  end

endmodule

`default_nettype wire

//--- cache_system.f
cache_pkg.sv
burst_ram.sv
cache_instr.sv
cache_data.sv
cache.sv
cache_system.sv
tb_cache_system.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cache system testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cache_system -f cache_system.f \
  -o sim_cache_system
./obj_dir/sim_cache_system | tee sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  exit 1
fi
